//--- tests/fm_regs_patterns.txt
# W part reg data (hex) | S slot field expected(hex) | D clk_en spacing (dec)
# B reg data busy_ticks(dec) | T timer(A/B) clk_en ticks to flag (dec, 0 = flag stays low)
D 6
W 0 2E 00
D 3
W 0 2F 00
D 2
W 0 2E 00
D 2
W 0 2D 00
D 6
B 21 00 32
W 1 36 57
W 0 4D EA
W 1 58 F5
W 0 33 7F
S 11 mul 7
S 11 dt1 5
S 19 tl 6A
S 15 ks 3
S 15 ar 15
S 3 mul 0
W 1 A6 2D
W 1 A2 3C
W 0 B1 2E
S 5 fnum 53C
S 23 block 5
S 4 fnum 0
S 7 alg 6
S 19 fb 5
W 0 28 56
S 5 keyon 1
S 11 keyon 1
S 17 keyon 0
S 23 keyon 0
W 0 24 F0
W 0 25 00
W 0 27 05
T A 64
W 0 27 10
T A 0
W 0 27 01
T A 0
W 0 26 F0
W 0 27 0A
T B 256
W 0 27 20
T B 0

//--- vlog.f
common/fm_cfg_pkg.sv
common/fm_types_pkg.sv
common/reg_upd_if.sv
design/fm_clk_div.sv
regs/fm_mmr.sv
regs/fm_slot_regs.sv
design/fm_timers.sv
design/fm_regs_top.sv
tests/fm_regs_properties.sv
tests/fm_regs_tb.sv

//--- Bender.yml
package:
  name: fm_regs

sources:
  - common/fm_cfg_pkg.sv
  - common/fm_types_pkg.sv
  - common/reg_upd_if.sv
  - design/fm_clk_div.sv
  - regs/fm_mmr.sv
  - regs/fm_slot_regs.sv
  - design/fm_timers.sv
  - design/fm_regs_top.sv
  - target: test
    files:
      - tests/fm_regs_properties.sv
      - tests/fm_regs_tb.sv

//--- tests/fm_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fm_regs_tb;
    import fm_cfg_pkg::*;
    import fm_types_pkg::*;

    localparam int WAIT_CLKS   = 2000;   // per-wait limit, in clks
    localparam int TIMER_CLKS  = 60000;  // longest timer run
    localparam int QUIET_TICKS = 1100;   // covers a full timer A period

    logic       clk = 1'b0;
    logic       rst;
    logic       cen;
    logic       write;
    logic [1:0] addr;
    logic [7:0] din;

    logic      clk_en, busy, irq_n, flag_a, flag_b, keyon;
    slot_idx_t cur_slot;
    ch_idx_t   cur_ch;
    fnum_t     fnum;
    block_t    block;
    alg_t      alg;
    fb_t       fb;
    mul_t      mul;
    dt1_t      dt1;
    tl_t       tl;
    ar_t       ar;
    ks_t       ks;

    int    errors    = 0;
    int    checks    = 0;
    logic  timed_out = 1'b0;
    int    fd;
    string line;

    fm_regs_top fm_regs_top_inst (.*);

    always #20 clk = ~clk;  // 40 ns period

    task automatic compare_field(input string test, input fnum_t expected, input fnum_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0s: expected %0h, actual %0h", test, expected, actual);
        end
    endtask

    task automatic compare_count(input string test, input int expected, input int actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0s: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic compare_flag(input string test, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %0s: expected %b, actual %b", test, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;  // stops the pattern loop
        $display("timeout while waiting: %0s", what);
    endtask

    // zero-extended view of one slot output
    function automatic fnum_t slot_field(input logic [63:0] fld);
        case (fld)
            "mul":   return fnum_t'(mul);
            "dt1":   return fnum_t'(dt1);
            "tl":    return fnum_t'(tl);
            "ks":    return fnum_t'(ks);
            "ar":    return fnum_t'(ar);
            "fnum":  return fnum;
            "block": return fnum_t'(block);
            "alg":   return fnum_t'(alg);
            "fb":    return fnum_t'(fb);
            "keyon": return fnum_t'(keyon);
            default: begin
                $display("unknown slot field %0s in pattern file", fld);
                return 'x;
            end
        endcase
    endfunction

    function automatic logic timer_flag(input byte tmr);
        return (tmr == "B") ? flag_b : flag_a;
    endfunction

    task automatic idle_gap();
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic wait_busy_low();
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (busy && cyc < WAIT_CLKS) begin
            @(negedge clk);
            cyc++;
        end
        if (busy)
            report_timeout("busy never dropped before a write");
    endtask

    task automatic wait_clk_en();
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (!clk_en && cyc < WAIT_CLKS) begin
            @(negedge clk);
            cyc++;
        end
        if (!clk_en)
            report_timeout("no clk_en pulse");
    endtask

    // one clk of write, then write drops
    task automatic addr_write(input logic part, input logic [7:0] rg);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {part, 1'b0};
        din   <= rg;
        @(posedge clk);
        write <= 1'b0;
    endtask

    task automatic data_write(input logic part, input logic [7:0] data);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {part, 1'b1};
        din   <= data;
        @(posedge clk);
        write <= 1'b0;  // returns on the edge the DUT takes the data
    endtask

    task automatic bus_write(input logic part, input logic [7:0] rg, input logic [7:0] data);
        wait_busy_low();
        addr_write(part, rg);
        data_write(part, data);  // idle clk between, so busy sees an edge
    endtask

    task automatic check_slot(input int slot, input logic [63:0] fld, input int expv);
        int cyc;
        repeat (2) @(posedge clk);  // stored value shows two clks after the data write
        cyc = 0;
        @(negedge clk);
        while (cur_slot != slot_idx_t'(slot) && cyc < WAIT_CLKS) begin
            @(negedge clk);
            cyc++;
        end
        if (cur_slot != slot_idx_t'(slot)) begin
            report_timeout($sformatf("sequencer never reached slot %0d", slot));
        end else begin
            compare_field($sformatf("slot %0d %0s", slot, fld), fnum_t'(expv), slot_field(fld));
            // channel is the slot number modulo the channel count
            compare_field($sformatf("slot %0d channel", slot), fnum_t'(slot % NUM_CH),
                          fnum_t'(cur_ch));
        end
    endtask

    task automatic check_divider(input int expv);
        int gap;
        wait_clk_en();
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!clk_en && gap < WAIT_CLKS);
        if (!clk_en)
            report_timeout("second clk_en for the divider check");
        else
            compare_count("clk_en spacing", expv, gap);
    endtask

    task automatic check_busy(input logic [7:0] rg, input logic [7:0] data, input int expv);
        int   cyc;
        int   ticks;
        logic seen;
        wait_busy_low();
        addr_write(1'b0, rg);
        seen = 1'b0;
        repeat (4) begin
            @(negedge clk);
            seen |= busy;
        end
        compare_flag("busy after address write", 1'b0, seen);
        data_write(1'b0, data);
        ticks = 0;
        cyc   = 0;
        @(negedge clk);
        while (busy && cyc < WAIT_CLKS) begin
            if (clk_en)
                ticks++;  // ticks seen while busy is up
            @(negedge clk);
            cyc++;
        end
        if (busy)
            report_timeout("busy never fell");
        else
            compare_count("busy length in clk_en ticks", expv, ticks);
    endtask

    // count from the cycle after the load, flag seen on the next negedge
    task automatic check_timer(input byte tmr, input int expv);
        int   cyc;
        int   ticks;
        logic seen;
        @(negedge clk);  // load cycle, no step
        ticks = 0;
        cyc   = 0;
        if (expv > 0) begin
            @(negedge clk);
            while (!timer_flag(tmr) && cyc < TIMER_CLKS) begin
                if (clk_en)
                    ticks++;
                @(negedge clk);
                cyc++;
            end
            if (!timer_flag(tmr)) begin
                report_timeout($sformatf("timer %c flag", tmr));
            end else begin
                compare_count($sformatf("timer %c ticks to flag", tmr), expv, ticks);
                compare_flag("irq_n with flag set", 1'b0, irq_n);
            end
        end else begin
            seen = 1'b0;
            while (ticks < QUIET_TICKS && cyc < TIMER_CLKS) begin
                @(negedge clk);
                cyc++;
                seen |= timer_flag(tmr) || !irq_n;
                if (clk_en)
                    ticks++;
            end
            compare_flag($sformatf("timer %c flag or irq while quiet", tmr), 1'b0, seen);
        end
    endtask

    task automatic run_line(input string txt);
        logic [7:0]  part;
        logic [7:0]  rg;
        logic [7:0]  data;
        logic [63:0] fld;
        byte         tmr;
        int          slot;
        int          expv;
        int          n;
        int          want;  // fields this line kind needs
        n    = 0;
        want = 1;
        case (txt[0])
            "W": begin
                want = 3;
                n = $sscanf(txt, "W %h %h %h", part, rg, data);
                if (n == want)
                    bus_write(part[0], rg, data);
            end
            "S": begin
                want = 3;
                n = $sscanf(txt, "S %d %s %h", slot, fld, expv);
                if (n == want)
                    check_slot(slot, fld, expv);
            end
            "T": begin
                want = 2;
                n = $sscanf(txt, "T %c %d", tmr, expv);
                if (n == want)
                    check_timer(tmr, expv);
            end
            "D": begin
                want = 1;
                n = $sscanf(txt, "D %d", expv);
                if (n == want)
                    check_divider(expv);
            end
            "B": begin
                want = 3;
                n = $sscanf(txt, "B %h %h %d", rg, data, expv);
                if (n == want)
                    check_busy(rg, data, expv);
            end
            default: n = 0;
        endcase
        if (n != want) begin
            errors++;
            $display("pattern line could not be parsed: %0s", txt);
        end
    endtask

    initial begin
        void'($urandom(32'hdac92c62));
        rst   = 1'b1;
        cen   = 1'b1;  // host cen held high throughout
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("tests/fm_regs_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open tests/fm_regs_patterns.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(line, fd) == 0)
                    continue;
                if (line.len() < 2 || line[0] == "#")
                    continue;  // blank or comment
                if (line[0] != "T")
                    idle_gap();  // timer checks count from the load write
                run_line(line);
            end
            $fclose(fd);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/fm_regs_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fm_regs_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen,
    input logic                    clk_en,
    input logic                    busy,
    input logic                    irq_n,
    input logic                    flag_a,
    input logic                    flag_b,
    input fm_types_pkg::slot_idx_t cur_slot
);
    import fm_cfg_pkg::*;

    // prescaler only ticks on host cen, and never on two clks running
    a_clk_en_cen: assert property (@(posedge clk) disable iff (rst)
        clk_en |-> cen && !$past(clk_en))
        else $error("clk_en high while cen low or on two clks running");

    // busy ends on a synthesis tick
    a_busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(clk_en))
        else $error("busy fell outside a clk_en cycle");

    a_irq_level: assert property (@(posedge clk) disable iff (rst) irq_n == !(flag_a || flag_b))
        else $error("irq_n does not match the timer flags");

    a_slot_range: assert property (@(posedge clk) disable iff (rst) cur_slot < NUM_SLOT)
        else $error("cur_slot out of range");

endmodule

bind fm_regs_top fm_regs_properties fm_regs_properties_inst (.*);

`default_nettype wire

//--- design/fm_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

module fm_regs_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    write,
    input  logic [1:0]              addr,
    input  logic [7:0]              din,
    output logic                    clk_en,
    output logic                    busy,
    output logic                    irq_n,
    output logic                    flag_a,
    output logic                    flag_b,
    output fm_types_pkg::slot_idx_t cur_slot,
    output fm_types_pkg::ch_idx_t   cur_ch,
    output logic                    keyon,
    output fm_types_pkg::fnum_t     fnum,
    output fm_types_pkg::block_t    block,
    output fm_types_pkg::alg_t      alg,
    output fm_types_pkg::fb_t       fb,
    output fm_types_pkg::mul_t      mul,
    output fm_types_pkg::dt1_t      dt1,
    output fm_types_pkg::tl_t       tl,
    output fm_types_pkg::ar_t       ar,
    output fm_types_pkg::ks_t       ks
);
    import fm_types_pkg::*;

    div_sel_e   div_sel;
    logic [9:0] value_a;
    logic [7:0] value_b;
    logic       load_a, load_b;
    logic       irq_en_a, irq_en_b;
    logic       clr_a, clr_b;

    reg_upd_if upd_bus ();  // decoder to slot store

    fm_clk_div fm_clk_div_inst (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    fm_mmr fm_mmr_inst (
        .clk      (clk),
        .rst      (rst),
        .clk_en   (clk_en),
        .write    (write),
        .addr     (addr),
        .din      (din),
        .busy     (busy),
        .div_sel  (div_sel),
        .value_a  (value_a),
        .value_b  (value_b),
        .load_a   (load_a),
        .load_b   (load_b),
        .irq_en_a (irq_en_a),
        .irq_en_b (irq_en_b),
        .clr_a    (clr_a),
        .clr_b    (clr_b),
        .upd      (upd_bus.decoder)
    );

    fm_slot_regs fm_slot_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .clk_en   (clk_en),
        .upd      (upd_bus.store),
        .cur_slot (cur_slot),
        .cur_ch   (cur_ch),
        .keyon    (keyon),
        .fnum     (fnum),
        .block    (block),
        .alg      (alg),
        .fb       (fb),
        .mul      (mul),
        .dt1      (dt1),
        .tl       (tl),
        .ar       (ar),
        .ks       (ks)
    );

    fm_timers fm_timers_inst (
        .clk      (clk),
        .rst      (rst),
        .clk_en   (clk_en),
        .value_a  (value_a),
        .value_b  (value_b),
        .load_a   (load_a),
        .load_b   (load_b),
        .irq_en_a (irq_en_a),
        .irq_en_b (irq_en_b),
        .clr_a    (clr_a),
        .clr_b    (clr_b),
        .flag_a   (flag_a),
        .flag_b   (flag_b),
        .irq_n    (irq_n)
    );

endmodule

`default_nettype wire

//--- design/fm_timers.sv
`timescale 1ns/1ps
`default_nettype none

module fm_timers (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  logic [9:0] value_a,
    input  logic [7:0] value_b,
    input  logic       load_a,
    input  logic       load_b,
    input  logic       irq_en_a,
    input  logic       irq_en_b,
    input  logic       clr_a,
    input  logic       clr_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);
    import fm_cfg_pkg::*;

    logic [9:0]       cnt_a;
    logic [7:0]       cnt_b;
    logic [TBP_W-1:0] pre_b;   // timer B prescaler
    logic             load_a_q;
    logic             load_b_q;

    wire step_b = clk_en && (pre_b == TBP_W'(TB_PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a    <= '0;
            cnt_b    <= '0;
            pre_b    <= '0;
            load_a_q <= 1'b0;
            load_b_q <= 1'b0;
            flag_a   <= 1'b0;
            flag_b   <= 1'b0;
        end else begin
            load_a_q <= load_a;
            load_b_q <= load_b;
            if (clr_a) flag_a <= 1'b0;
            if (clr_b) flag_b <= 1'b0;

            // timer A, one step per tick
            if (load_a && !load_a_q) begin
                cnt_a <= value_a;
            end else if (clk_en && load_a) begin
                if (&cnt_a) begin
                    cnt_a <= value_a;          // reload on overflow
                    if (irq_en_a) flag_a <= 1'b1;
                end else begin
                    cnt_a <= cnt_a + 10'd1;
                end
            end

            // timer B, one step per 16 ticks
            if (load_b && !load_b_q) begin
                cnt_b <= value_b;
                pre_b <= '0;
            end else if (clk_en && load_b) begin
                pre_b <= pre_b + TBP_W'(1);   // wraps at 16
                if (step_b) begin
                    if (&cnt_b) begin
                        cnt_b <= value_b;
                        if (irq_en_b) flag_b <= 1'b1;
                    end else begin
                        cnt_b <= cnt_b + 8'd1;
                    end
                end
            end
        end
    end

    assign irq_n = !(flag_a || flag_b);  // active low

endmodule

`default_nettype wire

//--- regs/fm_slot_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fm_slot_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clk_en,
    reg_upd_if.store                upd,
    output fm_types_pkg::slot_idx_t cur_slot,
    output fm_types_pkg::ch_idx_t   cur_ch,
    output logic                    keyon,
    output fm_types_pkg::fnum_t     fnum,
    output fm_types_pkg::block_t    block,
    output fm_types_pkg::alg_t      alg,
    output fm_types_pkg::fb_t       fb,
    output fm_types_pkg::mul_t      mul,
    output fm_types_pkg::dt1_t      dt1,
    output fm_types_pkg::tl_t       tl,
    output fm_types_pkg::ar_t       ar,
    output fm_types_pkg::ks_t       ks
);
    import fm_cfg_pkg::*;
    import fm_types_pkg::*;

    // per slot
    mul_t mul_r [NUM_SLOT];
    dt1_t dt1_r [NUM_SLOT];
    tl_t  tl_r  [NUM_SLOT];
    ar_t  ar_r  [NUM_SLOT];
    ks_t  ks_r  [NUM_SLOT];
    logic [NUM_SLOT-1:0] kon_r;

    // per channel
    fnum_t  fnum_r  [NUM_CH];
    block_t block_r [NUM_CH];
    alg_t   alg_r   [NUM_CH];
    fb_t    fb_r    [NUM_CH];
    logic [5:0] fnum_hi_lat;  // {block, fnum[10:8]}, one latch for all channels

    // op index in S1,S3,S2,S4 order
    function automatic slot_idx_t slot_of(input logic [1:0] op, input ch_idx_t ch);
        return slot_idx_t'(op) * slot_idx_t'(NUM_CH) + slot_idx_t'(ch);
    endfunction

    // key-on data fields
    wire [7:0] d        = upd.upd_data;
    wire [3:0] kon_ops  = {d[7], d[5], d[6], d[4]};  // S4,S2,S3,S1 by op index
    wire       kon_ok   = d[1:0] != 2'b11;
    wire ch_idx_t kon_ch = ch_idx_t'(d[2] ? 3'd3 : 3'd0) + ch_idx_t'(d[1:0]);

    wire slot_idx_t wr_slot = slot_of(upd.upd_op, upd.upd_ch);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOT; i++) begin
                mul_r[i] <= '0;
                dt1_r[i] <= '0;
                tl_r[i]  <= '0;
                ar_r[i]  <= '0;
                ks_r[i]  <= '0;
            end
            for (int c = 0; c < NUM_CH; c++) begin
                fnum_r[c]  <= '0;
                block_r[c] <= '0;
                alg_r[c]   <= '0;
                fb_r[c]    <= '0;
            end
            kon_r       <= '0;
            fnum_hi_lat <= '0;
        end else begin
            case (upd.upd_grp)
                UPD_DT1_MUL: {dt1_r[wr_slot], mul_r[wr_slot]} <= d[6:0];
                UPD_TL:      tl_r[wr_slot] <= d[6:0];
                UPD_KS_AR: begin
                    ks_r[wr_slot] <= d[7:6];
                    ar_r[wr_slot] <= d[4:0];
                end
                UPD_FNUM_HI: fnum_hi_lat <= d[5:0];
                UPD_FNUM_LO:  // commit latched msbs with the lsbs
                    {block_r[upd.upd_ch], fnum_r[upd.upd_ch]} <= {fnum_hi_lat, d};
                UPD_ALG_FB: {fb_r[upd.upd_ch], alg_r[upd.upd_ch]} <= d[5:0];
                UPD_KEYON: begin
                    if (kon_ok)
                        for (int op = 0; op < 4; op++)
                            kon_r[slot_of(2'(op), kon_ch)] <= kon_ops[op];
                end
                default: ;
            endcase
        end
    end

    // slot sequencer, one slot per tick
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_slot <= '0;
            cur_ch   <= '0;
        end else if (clk_en) begin
            cur_slot <= (cur_slot == slot_idx_t'(NUM_SLOT - 1)) ? '0 : cur_slot + 5'd1;
            cur_ch   <= (cur_ch == ch_idx_t'(NUM_CH - 1)) ? '0 : cur_ch + 3'd1;
        end
    end

    // current slot readout
    assign keyon = kon_r[cur_slot];
    assign mul   = mul_r[cur_slot];
    assign dt1   = dt1_r[cur_slot];
    assign tl    = tl_r[cur_slot];
    assign ar    = ar_r[cur_slot];
    assign ks    = ks_r[cur_slot];
    assign fnum  = fnum_r[cur_ch];
    assign block = block_r[cur_ch];
    assign alg   = alg_r[cur_ch];
    assign fb    = fb_r[cur_ch];

endmodule

`default_nettype wire

//--- regs/fm_mmr.sv
`timescale 1ns/1ps
`default_nettype none

module fm_mmr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clk_en,
    input  logic                   write,
    input  logic [1:0]             addr,
    input  logic [7:0]             din,
    output logic                   busy,
    output fm_types_pkg::div_sel_e div_sel,
    output logic [9:0]             value_a,
    output logic [7:0]             value_b,
    output logic                   load_a,
    output logic                   load_b,
    output logic                   irq_en_a,
    output logic                   irq_en_b,
    output logic                   clr_a,
    output logic                   clr_b,
    reg_upd_if.decoder             upd
);
    import fm_cfg_pkg::*;
    import fm_types_pkg::*;

    logic [7:0]        sel_reg;    // latched register number
    logic              part;       // addr[1] of the address write
    logic              old_write;
    logic [BUSY_W-1:0] busy_cnt;
    upd_grp_e          grp;        // group for the selected register

    wire data_wr = write && addr[0];

    // group decode from the latched address
    always_comb begin
        grp = UPD_NONE;
        if (sel_reg == REG_KON) begin
            grp = UPD_KEYON;
        end else if (sel_reg[1:0] != 2'b11) begin  // xx3/xx7/.. hit no channel
            case (sel_reg[7:4])
                ROW_DT1_MUL: grp = UPD_DT1_MUL;
                ROW_TL:      grp = UPD_TL;
                ROW_KS_AR:   grp = UPD_KS_AR;
                default: begin
                    if ({sel_reg[7:2], 2'b00} == REG_FNUM_LO)
                        grp = UPD_FNUM_LO;
                    else if ({sel_reg[7:2], 2'b00} == REG_FNUM_HI)
                        grp = UPD_FNUM_HI;
                    else if ({sel_reg[7:2], 2'b00} == REG_ALG_FB)
                        grp = UPD_ALG_FB;
                end
            endcase
        end
    end

    // address latch and global registers
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg  <= '0;
            part     <= 1'b0;
            div_sel  <= DIV_BY6;
            value_a  <= '0;
            value_b  <= '0;
            {clr_b, clr_a, irq_en_b, irq_en_a, load_b, load_a} <= '0;
        end else if (write) begin
            if (!addr[0]) begin
                sel_reg <= din;
                part    <= addr[1];
            end else begin
                case (sel_reg)
                    REG_TESTYM: ;  // test bits accepted, no effect
                    REG_CLKA1:  value_a[9:2] <= din;
                    REG_CLKA2:  value_a[1:0] <= din[1:0];
                    REG_CLKB:   value_b      <= din;
                    REG_TIMER:
                        {clr_b, clr_a, irq_en_b, irq_en_a, load_b, load_a} <= din[5:0];
                    REG_CLK_N6: div_sel <= DIV_BY6;
                    REG_CLK_N3: if (div_sel == DIV_BY6) div_sel <= DIV_BY3;
                    REG_CLK_N2: div_sel <= DIV_BY2;
                    default: ;
                endcase
            end
        end else if (clk_en) begin
            {clr_b, clr_a} <= 2'b00;  // clear pulses end on next tick
        end
    end

    // update pulse, one cycle after the data write
    always_ff @(posedge clk) begin
        if (rst)
            upd.upd_grp <= UPD_NONE;
        else
            upd.upd_grp <= data_wr ? grp : UPD_NONE;
    end

    // payload follows the pulse
    always_ff @(posedge clk) begin
        if (data_wr) begin
            upd.upd_ch   <= ch_idx_t'(part ? 3'd3 : 3'd0) + ch_idx_t'(sel_reg[1:0]);
            upd.upd_op   <= sel_reg[3:2];
            upd.upd_data <= din;
        end
    end

    // busy, restarted by each data write edge
    always_ff @(posedge clk) begin
        if (rst) begin
            old_write <= 1'b0;
            busy      <= 1'b0;
            busy_cnt  <= '0;
        end else begin
            old_write <= write;
            if (data_wr && !old_write) begin
                busy     <= 1'b1;
                busy_cnt <= '0;
            end else if (clk_en && busy) begin
                if (busy_cnt == BUSY_W'(BUSY_TICKS - 1))
                    busy <= 1'b0;  // last tick
                busy_cnt <= busy_cnt + BUSY_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/fm_clk_div.sv
`timescale 1ns/1ps
`default_nettype none

module fm_clk_div (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  fm_types_pkg::div_sel_e div_sel,
    output logic                   clk_en
);
    import fm_cfg_pkg::*;
    import fm_types_pkg::*;

    logic [DIV_W-1:0] cnt;
    logic [DIV_W-1:0] term;   // ratio minus one
    div_sel_e         sel_q;  // last setting seen

    always_comb begin
        case (div_sel)
            DIV_BY3: term = DIV_W'(DIV3 - 1);
            DIV_BY2: term = DIV_W'(DIV2 - 1);
            default: term = DIV_W'(DIV6 - 1);
        endcase
    end

    // no tick in the cycle the ratio changes, count may be past the new term
    assign clk_en = cen && (cnt == term) && (div_sel == sel_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            sel_q <= DIV_BY6;
        end else begin
            sel_q <= div_sel;
            if (div_sel != sel_q)
                cnt <= '0;  // restart on new ratio
            else if (cen)
                cnt <= (cnt == term) ? '0 : cnt + DIV_W'(1);
        end
    end

endmodule

`default_nettype wire

//--- common/reg_upd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_upd_if;
    import fm_types_pkg::*;

    upd_grp_e    upd_grp;   // one-clk pulse, UPD_NONE when idle
    ch_idx_t     upd_ch;    // part*3 + addr[1:0]
    logic [1:0]  upd_op;    // 0=S1 1=S3 2=S2 3=S4
    logic [7:0]  upd_data;

    modport decoder (
        output upd_grp, upd_ch, upd_op, upd_data
    );

    modport store (
        input upd_grp, upd_ch, upd_op, upd_data
    );

endinterface

`default_nettype wire

//--- common/fm_types_pkg.sv
`default_nettype none

package fm_types_pkg;

    // global register map, part independent
    typedef enum logic [7:0] {
        REG_TESTYM = 8'h21,  // test bits, ignored here
        REG_CLKA1  = 8'h24,  // timer A msbs
        REG_CLKA2  = 8'h25,  // timer A lsbs
        REG_CLKB   = 8'h26,
        REG_TIMER  = 8'h27,  // load / enable / clear
        REG_KON    = 8'h28,
        REG_CLK_N6 = 8'h2D,
        REG_CLK_N3 = 8'h2E,
        REG_CLK_N2 = 8'h2F
    } fm_reg_e;

    // which parameter group a data write touches
    typedef enum logic [2:0] {
        UPD_NONE,
        UPD_DT1_MUL,  // 30h row
        UPD_TL,       // 40h row
        UPD_KS_AR,    // 50h row
        UPD_FNUM_HI,  // A4h row, latched only
        UPD_FNUM_LO,  // A0h row, commits fnum and block
        UPD_ALG_FB,   // B0h row
        UPD_KEYON
    } upd_grp_e;

    typedef enum logic [1:0] {
        DIV_BY6,
        DIV_BY3,
        DIV_BY2
    } div_sel_e;

    // slot output fields
    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;
    typedef logic [2:0]  alg_t;
    typedef logic [2:0]  fb_t;
    typedef logic [3:0]  mul_t;
    typedef logic [2:0]  dt1_t;
    typedef logic [6:0]  tl_t;
    typedef logic [4:0]  ar_t;
    typedef logic [1:0]  ks_t;

    typedef logic [2:0] ch_idx_t;
    typedef logic [4:0] slot_idx_t;

endpackage

`default_nettype wire

//--- common/fm_cfg_pkg.sv
`default_nettype none

package fm_cfg_pkg;

    // core geometry
    localparam int NUM_CH   = 6;
    localparam int NUM_SLOT = 24;  // 4 operators x 6 channels

    // busy strobe, counted in synthesis ticks
    localparam int BUSY_TICKS = 32;
    localparam int BUSY_W     = $clog2(BUSY_TICKS);

    // timer B runs off a /16 prescaler
    localparam int TB_PRESCALE = 16;
    localparam int TBP_W       = $clog2(TB_PRESCALE);

    // host cen to synthesis tick ratios
    localparam int DIV6  = 6;
    localparam int DIV3  = 3;
    localparam int DIV2  = 2;
    localparam int DIV_W = $clog2(DIV6);

    // operator register rows, upper nibble of the address
    localparam logic [3:0] ROW_DT1_MUL = 4'h3;
    localparam logic [3:0] ROW_TL      = 4'h4;
    localparam logic [3:0] ROW_KS_AR   = 4'h5;

    // channel register rows, low two bits pick the channel
    localparam logic [7:0] REG_FNUM_LO = 8'hA0;
    localparam logic [7:0] REG_FNUM_HI = 8'hA4;
    localparam logic [7:0] REG_ALG_FB  = 8'hB0;

endpackage

`default_nettype wire
